/* Makefile */
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

obj_dir/V%: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module $* -f tb.f

run: obj_dir/Vtb_sdram
	./obj_dir/Vtb_sdram | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

/* common/sdram_pkg.sv */
package sdram_pkg;

	localparam int burst_len = 8;	// words per line
	localparam int bank_w = 2;
	localparam int row_w = 13;
	localparam int col_w = 9;

	localparam int init_wait_cycles = 10000;	// 200 us power-up wait
	localparam int refresh_interval = 390;	// one auto refresh per 7.8 us
	localparam int t_rcd = 2;
	localparam int t_rp = 2;
	localparam int t_rfc = 4;
	localparam int t_wr = 2;
	localparam int t_mrd = 2;
	localparam int cas_latency = 2;
	localparam int rd_capture_delay = cas_latency + 1;	// READ pin cycle to first sample
	localparam int rd_recover = rd_capture_delay + 1 - t_rp;	// last word lands with burst_done

	// init sequence, counted from reset release
	localparam int init_pre_at = init_wait_cycles;
	localparam int init_ref1_at = init_pre_at + t_rp;
	localparam int init_ref2_at = init_ref1_at + t_rfc;
	localparam int init_mode_at = init_ref2_at + t_rfc;
	localparam int init_end_at = init_mode_at + t_mrd;

	// burst write, CL, sequential, burst of 8
	localparam logic [12:0] mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'b011};

	typedef logic [2:0] word_index_t;

	typedef struct packed {
		logic [15:0] w7;
		logic [15:0] w6;
		logic [15:0] w5;
		logic [15:0] w4;
		logic [15:0] w3;
		logic [15:0] w2;
		logic [15:0] w1;
		logic [15:0] w0;	// lowest address
	} line_t;

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		cmd_load_mode = 4'b0000,
		cmd_auto_refresh = 4'b0001,
		cmd_precharge = 4'b0010,
		cmd_active = 4'b0011,
		cmd_write = 4'b0100,
		cmd_read = 4'b0101,
		cmd_nop = 4'b0111
	} cmd_t;

endpackage

/* dv/sdram_assert.sv */
module sdram_assert (
	input logic clk_50m,
	input logic rst_n,
	input logic init_done,
	input logic dq_oe_next,
	input logic rd_cmd,
	input logic cs_n,
	input logic ras_n,
	input logic cas_n,
	input logic we_n,
	input logic [1:0] ba,
	input logic a10
);

timeunit 1ns;
timeprecision 100ps;

localparam int ref_limit = sdram_pkg::refresh_interval + 40;	// interval plus longest access
localparam int hist_w = sdram_pkg::rd_capture_delay - 1 + sdram_pkg::burst_len;

logic [3:0] cmd;
int since_ref;
logic [3:0] bank_open;
logic [hist_w-1:0] rd_hist;	// bit i set when READ was i+1 cycles ago
logic rd_window;

assign cmd = {cs_n, ras_n, cas_n, we_n};
assign rd_window = |rd_hist[sdram_pkg::rd_capture_delay-1 +: sdram_pkg::burst_len];

always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		since_ref <= 0;
		bank_open <= 4'b0000;
		rd_hist <= '0;
	end else begin
		if (!init_done || cmd == sdram_pkg::cmd_auto_refresh) begin
			since_ref <= 0;
		end else begin
			since_ref <= since_ref + 1;
		end
		if (cmd == sdram_pkg::cmd_active) begin
			bank_open[ba] <= 1'b1;
		end else if (cmd == sdram_pkg::cmd_precharge) begin
			if (a10) begin
				bank_open <= 4'b0000;
			end else begin
				bank_open[ba] <= 1'b0;
			end
		end
		rd_hist <= {rd_hist[hist_w-2:0], rd_cmd};
	end
end

a_refresh: assert property (@(posedge clk_50m) disable iff (!rst_n)
	since_ref < ref_limit) else $error("auto refresh missing for %0d cycles", ref_limit);

a_bank_open: assert property (@(posedge clk_50m) disable iff (!rst_n)
	(cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write) |-> bank_open[ba])
	else $error("READ or WRITE to bank %0d without ACTIVE", ba);

a_bus_turn: assert property (@(posedge clk_50m) disable iff (!rst_n)
	!(dq_oe_next && rd_window)) else $error("write drive overlaps read data");

a_init_cmds: assert property (@(posedge clk_50m) disable iff (!rst_n)
	!init_done |-> (cmd != sdram_pkg::cmd_active && cmd != sdram_pkg::cmd_read &&
	cmd != sdram_pkg::cmd_write)) else $error("row command on the pins before init_done");

endmodule

bind sdram_sched sdram_assert u_sdram_assert (
	.clk_50m(clk_50m),
	.rst_n(rst_n),
	.init_done(init_done),
	.dq_oe_next(dq_oe_next),
	.rd_cmd(rd_cmd),
	.cs_n(sdram_cs_n),
	.ras_n(sdram_ras_n),
	.cas_n(sdram_cas_n),
	.we_n(sdram_we_n),
	.ba(sdram_ba),
	.a10(sdram_addr[10])
);

/* dv/sdram_model.sv */
module sdram_model (
	input logic sdram_clk,
	input logic cke,
	input logic cs_n,
	input logic ras_n,
	input logic cas_n,
	input logic we_n,
	input logic [1:0] ba,
	input logic [12:0] addr,
	inout wire [15:0] dq,
	input logic [1:0] dqm
);

timeunit 1ns;
timeprecision 100ps;

logic [15:0] mem [logic [23:0]];	// sparse, keyed by {bank, row, col}
logic [12:0] open_row [4];
logic [3:0] row_open = 4'b0000;
int cyc = 0;
int rd_at = -100;
int wr_at = -100;
logic [23:0] rd_base;
logic [23:0] wr_base;
logic drv_en = 1'b0;
logic [15:0] drv_val = 16'h0000;

assign dq = drv_en ? drv_val : 16'hzzzz;

// unwritten words read back as a pattern of their full address
function automatic logic [15:0] fill_word(input logic [23:0] a);
	return a[15:0] ^ {a[7:0], a[23:16]};
endfunction

function automatic logic [15:0] read_word(input logic [23:0] key);
	if (mem.exists(key)) begin
		return mem[key];
	end
	return fill_word(key);
endfunction

always @(posedge sdram_clk) begin
	logic [3:0] cmd;
	logic [23:0] wr_key;
	logic [15:0] old_word;
	cmd = {cs_n, ras_n, cas_n, we_n};
	if (cke) begin
		case (cmd)
			4'b0011: begin	// ACTIVE
				open_row[ba] = addr;
				row_open[ba] = 1'b1;
			end
			4'b0010: begin	// PRECHARGE
				if (addr[10]) begin
					row_open = 4'b0000;
				end else begin
					row_open[ba] = 1'b0;
				end
			end
			4'b0101: begin	// READ
				if (row_open[ba]) begin	// closed bank returns nothing
					rd_base = {ba, open_row[ba], addr[8:0]};
					rd_at = cyc + sdram_pkg::cas_latency;
				end
			end
			4'b0100: begin	// WRITE, first word comes with the command
				if (row_open[ba]) begin	// closed bank stores nothing
					wr_base = {ba, open_row[ba], addr[8:0]};
					wr_at = cyc;
				end
			end
			default: begin
			end
		endcase
	end
	if (cyc >= wr_at && cyc < wr_at + sdram_pkg::burst_len) begin
		wr_key = wr_base + 24'(cyc - wr_at);
		old_word = read_word(wr_key);
		mem[wr_key] = {dqm[1] ? old_word[15:8] : dq[15:8],
			dqm[0] ? old_word[7:0] : dq[7:0]};	// masked bytes keep their old value
	end
	if (cyc >= rd_at && cyc < rd_at + sdram_pkg::burst_len) begin
		drv_en <= 1'b1;
		drv_val <= read_word(rd_base + 24'(cyc - rd_at));
	end else begin
		drv_en <= 1'b0;
	end
	cyc = cyc + 1;
end

endmodule

/* dv/tb_sdram.sv */
module tb_sdram;

timeunit 1ns;
timeprecision 100ps;

localparam int n_entries = 8;
localparam int clk_period = 20;

logic clk_50m;
logic rst_n;
logic [23:0] addr;
logic wr;
logic rd;
logic valid;
sdram_pkg::line_t data_line_in;
sdram_pkg::line_t data_line_out;
logic done;
logic sdram_init_done;
logic sdram_clk;
logic sdram_cke;
logic sdram_cs_n;
logic sdram_ras_n;
logic sdram_cas_n;
logic sdram_we_n;
logic [1:0] sdram_ba;
logic [12:0] sdram_addr;
wire [15:0] sdram_data;
logic [1:0] sdram_dqm;

// stimulus table with expected read lines
logic op_wr [n_entries];
logic [23:0] addr_tab [n_entries];
int gap_tab [n_entries];
sdram_pkg::line_t data_tab [n_entries];
sdram_pkg::line_t exp_tab [n_entries];

logic [31:0] seed;
int err_cnt;
int done_cnt;
logic done_q;
logic init_seen;
logic have_read;
sdram_pkg::line_t last_read;

sdram_top u_sdram_top (
	.clk_50m(clk_50m),
	.rst_n(rst_n),
	.addr(addr),
	.wr(wr),
	.rd(rd),
	.valid(valid),
	.data_line_in(data_line_in),
	.data_line_out(data_line_out),
	.done(done),
	.sdram_init_done(sdram_init_done),
	.sdram_clk(sdram_clk),
	.sdram_cke(sdram_cke),
	.sdram_cs_n(sdram_cs_n),
	.sdram_ras_n(sdram_ras_n),
	.sdram_cas_n(sdram_cas_n),
	.sdram_we_n(sdram_we_n),
	.sdram_ba(sdram_ba),
	.sdram_addr(sdram_addr),
	.sdram_data(sdram_data),
	.sdram_dqm(sdram_dqm)
);

sdram_model u_sdram_model (
	.sdram_clk(sdram_clk),
	.cke(sdram_cke),
	.cs_n(sdram_cs_n),
	.ras_n(sdram_ras_n),
	.cas_n(sdram_cas_n),
	.we_n(sdram_we_n),
	.ba(sdram_ba),
	.addr(sdram_addr),
	.dq(sdram_data),
	.dqm(sdram_dqm)
);

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_value(input string name, input logic [127:0] got,
	input logic [127:0] exp);
	if (got !== exp) begin
		err_cnt = err_cnt + 1;
		$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("ERRORS FOUND");
		$fatal(1);
	end
endtask

// three lines in different banks, revisited for overwrite and read back
task automatic build_table();
	logic [1:0] bank_sel [3] = '{2'd0, 2'd1, 2'd3};
	int pick [n_entries] = '{0, 0, 1, 2, 1, 0, 2, 0};
	logic wr_pat [n_entries] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
	logic [23:0] base [3];
	sdram_pkg::line_t sb [logic [23:0]];
	sdram_pkg::line_t ln;
	for (int b = 0; b < 3; b++) begin
		seed = lcg_next(seed);
		base[b] = {bank_sel[b], seed[20:8], seed[5:0], 3'b000};
	end
	for (int i = 0; i < n_entries; i++) begin
		op_wr[i] = wr_pat[i];
		addr_tab[i] = base[pick[i]];
		seed = lcg_next(seed);
		if (i == 0) begin
			gap_tab[i] = 0;	// request waits on init from reset
		end else if (i == 4 || i == 7) begin
			gap_tab[i] = sdram_pkg::refresh_interval + 5 + int'(seed[4:0]);
		end else begin
			gap_tab[i] = int'(seed[2:0]);
		end
		ln = '0;
		if (wr_pat[i]) begin
			for (int k = 0; k < 8; k++) begin
				seed = lcg_next(seed);
				ln[16*k +: 16] = seed[31:16];
			end
			sb[addr_tab[i]] = ln;
			exp_tab[i] = ln;
		end else begin
			exp_tab[i] = sb[addr_tab[i]];
		end
		data_tab[i] = ln;
	end
endtask

initial begin
	clk_50m = 1'b0;
	forever #(clk_period / 2) clk_50m = ~clk_50m;
end

// done shape and init_done stability
always @(negedge clk_50m) begin
	if (rst_n) begin
		if (done) begin
			check_value("done in previous cycle", done_q, 1'b0);
			check_value("sdram_init_done", sdram_init_done, 1'b1);
			done_cnt = done_cnt + 1;
		end
		if (init_seen) begin
			check_value("sdram_init_done", sdram_init_done, 1'b1);
		end
		if (sdram_init_done) begin
			init_seen = 1'b1;
		end
		done_q = done;
	end
end

initial begin
	#(clk_period * (sdram_pkg::init_wait_cycles + 400 * n_entries));
	$display("timeout: done never arrived for the current request");
	$display("ERRORS FOUND");
	$fatal(1);
end

initial begin
	rst_n = 1'b0;
	valid = 1'b0;
	wr = 1'b0;
	rd = 1'b0;
	addr = 24'h000000;
	data_line_in = '0;
	err_cnt = 0;
	done_cnt = 0;
	done_q = 1'b0;
	init_seen = 1'b0;
	have_read = 1'b0;
	last_read = '0;
	seed = 32'h0bdb_86e9;
	build_table();
	repeat (3) @(posedge clk_50m);
	rst_n <= 1'b1;
	for (int i = 0; i < n_entries; i++) begin
		repeat (gap_tab[i]) @(posedge clk_50m);
		@(posedge clk_50m);
		check_value("done count", done_cnt, i);
		if (have_read) begin
			check_value("data_line_out", data_line_out, last_read);	// held between reads
		end
		valid <= 1'b1;
		wr <= op_wr[i];
		rd <= !op_wr[i];
		addr <= addr_tab[i];
		data_line_in <= data_tab[i];
		do @(negedge clk_50m); while (!done);
		check_value("sdram_init_done", sdram_init_done, 1'b1);
		if (!op_wr[i]) begin
			check_value("data_line_out", data_line_out, exp_tab[i]);
			last_read = exp_tab[i];
			have_read = 1'b1;
		end else if (have_read) begin
			check_value("data_line_out", data_line_out, last_read);
		end
		@(posedge clk_50m);
		valid <= 1'b0;
		wr <= 1'b0;
		rd <= 1'b0;
		@(negedge clk_50m);
		check_value("done", done, 1'b0);
	end
	repeat (2) @(posedge clk_50m);
	check_value("done count", done_cnt, n_entries);
	if (err_cnt == 0) begin
		$display("NO ERRORS");
		$finish;
	end else begin
		$display("ERRORS FOUND");
		$fatal(1);
	end
end

endmodule

/* hdl/sdram_top.sv */
module sdram_top (
	input logic clk_50m,
	input logic rst_n,
	input logic [23:0] addr,	// 16-bit word address
	input logic wr,
	input logic rd,
	input logic valid,
	input sdram_pkg::line_t data_line_in,
	output sdram_pkg::line_t data_line_out,
	output logic done,
	output logic sdram_init_done,
	output logic sdram_clk,
	output logic sdram_cke,
	output logic sdram_cs_n,
	output logic sdram_ras_n,
	output logic sdram_cas_n,
	output logic sdram_we_n,
	output logic [1:0] sdram_ba,
	output logic [12:0] sdram_addr,
	inout wire [15:0] sdram_data,
	output logic [1:0] sdram_dqm
);

sdram_pkg::cmd_t init_cmd;
logic [12:0] init_addr;
logic sched_ready;
logic start_wr;
logic start_rd;
logic wr_word_req;
sdram_pkg::word_index_t wr_index;
logic [15:0] wr_word;
logic rd_cmd;
logic dq_oe_next;
logic burst_done;
logic rd_valid;
sdram_pkg::word_index_t rd_index;
logic [15:0] rd_word;

sdram_line u_sdram_line (
	.clk_50m(clk_50m),
	.rst_n(rst_n),
	.wr(wr),
	.rd(rd),
	.valid(valid),
	.data_line_in(data_line_in),
	.data_line_out(data_line_out),
	.done(done),
	.init_done(sdram_init_done),
	.sched_ready(sched_ready),
	.start_wr(start_wr),
	.start_rd(start_rd),
	.wr_word_req(wr_word_req),
	.wr_index(wr_index),
	.wr_word(wr_word),
	.rd_valid(rd_valid),
	.rd_index(rd_index),
	.rd_word(rd_word),
	.burst_done(burst_done)
);

sdram_init u_sdram_init (
	.clk_50m(clk_50m),
	.rst_n(rst_n),
	.init_cmd(init_cmd),
	.init_addr(init_addr),
	.init_done(sdram_init_done)
);

sdram_sched u_sdram_sched (
	.clk_50m(clk_50m),
	.rst_n(rst_n),
	.init_cmd(init_cmd),
	.init_addr(init_addr),
	.init_done(sdram_init_done),
	.addr(addr),
	.start_wr(start_wr),
	.start_rd(start_rd),
	.sched_ready(sched_ready),
	.wr_word_req(wr_word_req),
	.wr_index(wr_index),
	.rd_cmd(rd_cmd),
	.dq_oe_next(dq_oe_next),
	.burst_done(burst_done),
	.sdram_cs_n(sdram_cs_n),
	.sdram_ras_n(sdram_ras_n),
	.sdram_cas_n(sdram_cas_n),
	.sdram_we_n(sdram_we_n),
	.sdram_ba(sdram_ba),
	.sdram_addr(sdram_addr)
);

sdram_dq u_sdram_dq (
	.clk_50m(clk_50m),
	.rst_n(rst_n),
	.dq_oe_next(dq_oe_next),
	.wr_word(wr_word),
	.rd_cmd(rd_cmd),
	.sdram_data(sdram_data),
	.rd_valid(rd_valid),
	.rd_index(rd_index),
	.rd_word(rd_word),
	.sdram_clk(sdram_clk),
	.sdram_cke(sdram_cke),
	.sdram_dqm(sdram_dqm)
);

endmodule

/* sdram/sdram_dq.sv */
module sdram_dq (
	input logic clk_50m,
	input logic rst_n,
	input logic dq_oe_next,
	input logic [15:0] wr_word,
	input logic rd_cmd,
	inout wire [15:0] sdram_data,
	output logic rd_valid,
	output sdram_pkg::word_index_t rd_index,
	output logic [15:0] rd_word,
	output logic sdram_clk,
	output logic sdram_cke,
	output logic [1:0] sdram_dqm
);

logic oe_q;
logic [15:0] wr_q;
logic [15:0] dq_in_q;	// bus sampled every cycle
logic [sdram_pkg::rd_capture_delay-1:0] rd_pipe;	// one bit per cycle of read latency
sdram_pkg::word_index_t burst_cnt;

assign sdram_data = oe_q ? wr_q : 16'hzzzz;
assign sdram_clk = ~clk_50m;	// SDRAM samples mid-cycle
assign sdram_cke = 1'b1;
assign sdram_dqm = 2'b00;

// first word flagged by the pipe, the next seven by the counter
assign rd_valid = rd_pipe[sdram_pkg::rd_capture_delay-1] || (burst_cnt != 3'd0);
assign rd_index = burst_cnt;
assign rd_word = dq_in_q;

always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		oe_q <= 1'b0;
		rd_pipe <= '0;
		burst_cnt <= 3'd0;
	end else begin
		oe_q <= dq_oe_next;
		rd_pipe <= {rd_pipe[sdram_pkg::rd_capture_delay-2:0], rd_cmd};
		if (rd_valid) begin
			burst_cnt <= burst_cnt + 3'd1;	// back to 0 after word 7
		end
	end
end

always_ff @(posedge clk_50m) begin
	wr_q <= wr_word;
	dq_in_q <= sdram_data;
end

endmodule

/* sdram/sdram_init.sv */
module sdram_init (
	input logic clk_50m,
	input logic rst_n,
	output sdram_pkg::cmd_t init_cmd,
	output logic [12:0] init_addr,
	output logic init_done
);

logic [14:0] step_cnt;	// cycles since reset, stops at the end of the sequence

always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		step_cnt <= 15'd0;
	end else if (step_cnt != 15'(sdram_pkg::init_end_at)) begin
		step_cnt <= step_cnt + 15'd1;
	end
end

always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		init_cmd <= sdram_pkg::cmd_nop;
		init_addr <= 13'h0000;
		init_done <= 1'b0;
	end else begin
		init_cmd <= sdram_pkg::cmd_nop;
		init_addr <= 13'h0000;
		case (step_cnt)
			15'(sdram_pkg::init_pre_at): begin
				init_cmd <= sdram_pkg::cmd_precharge;
				init_addr <= 13'h0400;	// a10 high, all banks
			end
			15'(sdram_pkg::init_ref1_at): begin
				init_cmd <= sdram_pkg::cmd_auto_refresh;
			end
			15'(sdram_pkg::init_ref2_at): begin
				init_cmd <= sdram_pkg::cmd_auto_refresh;
			end
			15'(sdram_pkg::init_mode_at): begin
				init_cmd <= sdram_pkg::cmd_load_mode;
				init_addr <= sdram_pkg::mode_word;
			end
			default: begin
				init_cmd <= sdram_pkg::cmd_nop;
			end
		endcase
		if (step_cnt == 15'(sdram_pkg::init_end_at)) begin
			init_done <= 1'b1;	// sticky, counter parks here
		end
	end
end

endmodule

/* sdram/sdram_line.sv */
module sdram_line (
	input logic clk_50m,
	input logic rst_n,
	input logic wr,	// user write request
	input logic rd,	// user read request
	input logic valid,
	input sdram_pkg::line_t data_line_in,
	output sdram_pkg::line_t data_line_out,
	output logic done,
	input logic init_done,
	input logic sched_ready,
	output logic start_wr,
	output logic start_rd,
	input logic wr_word_req,
	input sdram_pkg::word_index_t wr_index,
	output logic [15:0] wr_word,
	input logic rd_valid,
	input sdram_pkg::word_index_t rd_index,
	input logic [15:0] rd_word,
	input logic burst_done
);

typedef enum logic [1:0] {
	l_idle,
	l_wait_wr,	// write burst in flight
	l_wait_rd,	// read burst in flight
	l_done
} state_t;

state_t state;
state_t state_nxt;
logic go;

// request accepted only when controller is up and free
assign go = valid && (wr || rd) && init_done && sched_ready;

assign start_wr = (state == l_idle) && go && wr;	// wr wins over rd
assign start_rd = (state == l_idle) && go && !wr;
assign done = (state == l_done);

always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		state <= l_idle;
	end else begin
		state <= state_nxt;
	end
end

always_comb begin
	state_nxt = state;
	case (state)
		l_idle: begin
			if (start_wr) begin
				state_nxt = l_wait_wr;
			end else if (start_rd) begin
				state_nxt = l_wait_rd;
			end
		end
		l_wait_wr, l_wait_rd: begin
			if (burst_done) begin
				state_nxt = l_done;
			end
		end
		l_done: begin
			state_nxt = l_idle;
		end
		default: begin
			state_nxt = l_idle;
		end
	endcase
end

// word for the scheduler, picked in the cycle it asks
always_comb begin
	wr_word = 16'h0000;
	if (wr_word_req) begin
		case (wr_index)
			3'd0: wr_word = data_line_in.w0;
			3'd1: wr_word = data_line_in.w1;
			3'd2: wr_word = data_line_in.w2;
			3'd3: wr_word = data_line_in.w3;
			3'd4: wr_word = data_line_in.w4;
			3'd5: wr_word = data_line_in.w5;
			3'd6: wr_word = data_line_in.w6;
			default: wr_word = data_line_in.w7;
		endcase
	end
end

// read words land at their own slot, rest of the line holds
always_ff @(posedge clk_50m) begin
	if (rd_valid) begin
		case (rd_index)
			3'd0: data_line_out.w0 <= rd_word;
			3'd1: data_line_out.w1 <= rd_word;
			3'd2: data_line_out.w2 <= rd_word;
			3'd3: data_line_out.w3 <= rd_word;
			3'd4: data_line_out.w4 <= rd_word;
			3'd5: data_line_out.w5 <= rd_word;
			3'd6: data_line_out.w6 <= rd_word;
			default: data_line_out.w7 <= rd_word;
		endcase
	end
end

endmodule

/* sdram/sdram_sched.sv */
module sdram_sched (
	input logic clk_50m,
	input logic rst_n,
	input sdram_pkg::cmd_t init_cmd,
	input logic [12:0] init_addr,
	input logic init_done,
	input logic [23:0] addr,	// word address, held by the user
	input logic start_wr,
	input logic start_rd,
	output logic sched_ready,
	output logic wr_word_req,
	output sdram_pkg::word_index_t wr_index,
	output logic rd_cmd,	// READ on the pins this cycle
	output logic dq_oe_next,
	output logic burst_done,
	output logic sdram_cs_n,
	output logic sdram_ras_n,
	output logic sdram_cas_n,
	output logic sdram_we_n,
	output logic [1:0] sdram_ba,
	output logic [12:0] sdram_addr
);

typedef enum logic [2:0] {
	s_idle,
	s_refresh,
	s_activate,
	s_trcd,
	s_write,
	s_read,
	s_recover,	// write recovery or read drain
	s_precharge	// t_rp wait after PRECHARGE
} state_t;

state_t state;
state_t state_nxt;
sdram_pkg::cmd_t cmd_q;
sdram_pkg::cmd_t cmd_nxt;
logic [1:0] ba_nxt;
logic [12:0] addr_nxt;
logic [2:0] wait_cnt;
sdram_pkg::word_index_t word_cnt;
logic op_wr;	// current access is a write
logic [8:0] ref_timer;
logic ref_pend;
logic [sdram_pkg::bank_w-1:0] bank;
logic [sdram_pkg::row_w-1:0] row;
logic [sdram_pkg::col_w-1:0] col;

assign bank = addr[sdram_pkg::col_w + sdram_pkg::row_w +: sdram_pkg::bank_w];
assign row = addr[sdram_pkg::col_w +: sdram_pkg::row_w];
assign col = {addr[sdram_pkg::col_w-1:3], 3'b000};	// line aligned

assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;
assign sched_ready = init_done && (state == s_idle) && !ref_pend;
assign wr_word_req = (state == s_write);
assign dq_oe_next = (state == s_write);
assign wr_index = word_cnt;
assign burst_done = (state == s_precharge) && (wait_cnt == 3'd0);

always_comb begin
	state_nxt = state;
	cmd_nxt = sdram_pkg::cmd_nop;
	ba_nxt = sdram_ba;
	addr_nxt = sdram_addr;
	case (state)
		s_idle: begin
			if (!init_done) begin
				cmd_nxt = init_cmd;	// init block owns the pins
				addr_nxt = init_addr;
			end else if (ref_pend) begin
				cmd_nxt = sdram_pkg::cmd_auto_refresh;
				state_nxt = s_refresh;
			end else if (start_wr || start_rd) begin
				state_nxt = s_activate;
			end
		end
		s_refresh: begin
			if (wait_cnt == 3'd0) begin
				state_nxt = s_idle;
			end
		end
		s_activate: begin
			cmd_nxt = sdram_pkg::cmd_active;
			ba_nxt = bank;
			addr_nxt = row;
			state_nxt = s_trcd;
		end
		s_trcd: begin
			if (wait_cnt == 3'd0) begin
				state_nxt = op_wr ? s_write : s_read;
			end
		end
		s_write, s_read: begin
			if (word_cnt == 3'd0) begin
				if (op_wr) begin
					cmd_nxt = sdram_pkg::cmd_write;
				end else begin
					cmd_nxt = sdram_pkg::cmd_read;
				end
				addr_nxt = {{(13 - sdram_pkg::col_w){1'b0}}, col};	// a10 low, no auto precharge
			end
			if (word_cnt == 3'(sdram_pkg::burst_len - 1)) begin
				state_nxt = s_recover;
			end
		end
		s_recover: begin
			if (wait_cnt == 3'd0) begin
				cmd_nxt = sdram_pkg::cmd_precharge;	// this bank only
				addr_nxt = 13'h0000;
				state_nxt = s_precharge;
			end
		end
		s_precharge: begin
			if (wait_cnt == 3'd0) begin
				state_nxt = s_idle;
			end
		end
		default: begin
			state_nxt = s_idle;
		end
	endcase
end

always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		state <= s_idle;
		cmd_q <= sdram_pkg::cmd_nop;
		sdram_ba <= 2'b00;
		sdram_addr <= 13'h0000;
		rd_cmd <= 1'b0;
		op_wr <= 1'b0;
		wait_cnt <= 3'd0;
		word_cnt <= 3'd0;
	end else begin
		state <= state_nxt;
		cmd_q <= cmd_nxt;
		sdram_ba <= ba_nxt;
		sdram_addr <= addr_nxt;
		rd_cmd <= (cmd_nxt == sdram_pkg::cmd_read);
		if (state == s_idle && start_wr) begin
			op_wr <= 1'b1;
		end else if (state == s_idle && start_rd) begin
			op_wr <= 1'b0;
		end
		if (state_nxt != state) begin
			case (state_nxt)
				s_refresh: wait_cnt <= 3'(sdram_pkg::t_rfc - 1);
				s_trcd: wait_cnt <= 3'(sdram_pkg::t_rcd - 2);	// ACTIVE issued from s_activate
				s_recover: wait_cnt <= op_wr ? 3'(sdram_pkg::t_wr - 1) :
					3'(sdram_pkg::rd_recover - 1);
				s_precharge: wait_cnt <= 3'(sdram_pkg::t_rp - 1);
				default: wait_cnt <= 3'd0;
			endcase
		end else if (wait_cnt != 3'd0) begin
			wait_cnt <= wait_cnt - 3'd1;
		end
		if (state == s_write || state == s_read) begin
			word_cnt <= word_cnt + 3'd1;	// wraps to 0 after the last word
		end else begin
			word_cnt <= 3'd0;
		end
	end
end

// refresh timer, request waits for the next idle
always_ff @(posedge clk_50m or negedge rst_n) begin
	if (!rst_n) begin
		ref_timer <= 9'd0;
		ref_pend <= 1'b0;
	end else if (init_done) begin
		if (ref_timer == 9'(sdram_pkg::refresh_interval - 1)) begin
			ref_timer <= 9'd0;
			ref_pend <= 1'b1;
		end else begin
			ref_timer <= ref_timer + 9'd1;
			if (state == s_idle && state_nxt == s_refresh) begin
				ref_pend <= 1'b0;
			end
		end
	end
end

endmodule

/* tb.f */
common/sdram_pkg.sv
sdram/sdram_line.sv
sdram/sdram_init.sv
sdram/sdram_sched.sv
sdram/sdram_dq.sv
hdl/sdram_top.sv
dv/sdram_model.sv
dv/sdram_assert.sv
dv/tb_sdram.sv
